// File: Makefile
TOP := alu_core_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		-f alu_core_top.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

// File: alu_core_top.f
source/alu_pkg.sv
source/cmd_receiver.sv
source/cmd_fifo.sv
source/alu_datapath.sv
source/alu_core_top.sv
test/tb_clock.sv
test/alu_core_assert.sv
test/alu_core_tb.sv

// File: source/alu_core_top.sv
module alu_core_top #(
    parameter int unsigned FIFO_DEPTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cmd_req,
    input  alu_pkg::cmd_t    cmd,
    output logic             cmd_ack,
    output logic             result_req,
    output alu_pkg::result_t result,
    input  logic             result_ack
);

    import alu_pkg::*;

    logic push;
    logic pop;
    logic full;
    logic empty;
    cmd_t push_data;
    cmd_t pop_data;

    cmd_receiver u_receiver (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_req   (cmd_req),
        .cmd       (cmd),
        .cmd_ack   (cmd_ack),
        .full      (full),
        .push      (push),
        .push_data (push_data)
    );

    cmd_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .pop_data  (pop_data),
        .full      (full),
        .empty     (empty)
    );

    alu_datapath u_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .empty      (empty),
        .pop_data   (pop_data),
        .pop        (pop),
        .result_req (result_req),
        .result     (result),
        .result_ack (result_ack)
    );

endmodule

// File: source/alu_datapath.sv
module alu_datapath (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             empty,
    input  alu_pkg::cmd_t    pop_data,
    output logic             pop,
    output logic             result_req,
    output alu_pkg::result_t result,
    input  logic             result_ack
);

    import alu_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_ACK,
        WAIT_RELEASE
    } tx_state_e;

    tx_state_e state;
    tx_state_e state_next;

    data_t regs [NUM_REGS];

    instr_t    instr;
    alu_op_e   opcode;
    logic      wr_en;
    logic      sel_a;
    logic      sel_b;
    reg_addr_t dst_addr;
    reg_addr_t src_a_addr;
    reg_addr_t src_b_addr;

    data_t       alu_a;
    data_t       alu_b;
    data_t       alu_result;
    logic [23:0] product;

    // Field decode
    assign instr      = pop_data.instr;
    assign opcode     = alu_op_e'(instr[OPC_MSB:OPC_LSB]);
    assign wr_en      = instr[WE_BIT];
    assign sel_a      = instr[SEL_A_BIT];
    assign sel_b      = instr[SEL_B_BIT];
    assign dst_addr   = instr[4:0];
    assign src_a_addr = {2'b00, instr[4:2]};
    assign src_b_addr = {3'b000, instr[1:0]};

    // Operand sources
    assign alu_a = sel_a ? regs[src_a_addr] : pop_data.operand_a;
    assign alu_b = sel_b ? regs[src_b_addr] : pop_data.operand_b;

    assign product = alu_a * alu_b;

    always_comb begin
        case (opcode)
            op_pass_a: alu_result = alu_a;
            op_pass_b: alu_result = alu_b;
            op_add:    alu_result = alu_a + alu_b;
            op_sub:    alu_result = alu_a - alu_b;
            op_and:    alu_result = alu_a & alu_b;
            op_or:     alu_result = alu_a | alu_b;
            op_xor:    alu_result = alu_a ^ alu_b;
            op_not_b:  alu_result = ~alu_b;
            op_shl_a:  alu_result = alu_a << 1;
            op_shr_a:  alu_result = alu_a >> 1;
            op_mul:    alu_result = product[11:0];
            op_swap_a: alu_result = {alu_a[5:0], alu_a[11:6]};
            default:   alu_result = alu_a;
        endcase
    end

    // One command in flight, so a pop only happens from IDLE
    assign pop = (state == IDLE) && !empty;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (pop) begin
                    state_next = WAIT_ACK;
                end
            end
            WAIT_ACK: begin
                if (result_ack) begin
                    state_next = WAIT_RELEASE;
                end
            end
            WAIT_RELEASE: begin
                if (!result_ack) begin
                    state_next = IDLE;
                end
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_req <= 1'b0;
        end else if (pop) begin
            result_req <= 1'b1;
        end else if (state == WAIT_ACK && result_ack) begin
            result_req <= 1'b0;
        end
    end

    // Held until the next pop, well past the ack
    always_ff @(posedge clk) begin
        if (pop) begin
            result.value <= alu_result;
            result.instr <= instr;
        end
    end

    // Write-back
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (pop && wr_en) begin
            regs[dst_addr] <= alu_result;
        end
    end

endmodule

// File: source/alu_pkg.sv
package alu_pkg;

    // Widths
    typedef logic [11:0] data_t;
    typedef logic [19:0] instr_t;
    typedef logic [4:0]  reg_addr_t;

    localparam int unsigned NUM_REGS = 32;

    // Instruction field positions
    localparam int unsigned OPC_MSB   = 19;
    localparam int unsigned OPC_LSB   = 15;
    localparam int unsigned WE_BIT    = 14;
    localparam int unsigned SEL_A_BIT = 6;
    localparam int unsigned SEL_B_BIT = 5;

    // Any opcode outside this list behaves as op_pass_a
    typedef enum logic [4:0] {
        op_pass_a = 5'd0,
        op_pass_b = 5'd1,
        op_add    = 5'd2,
        op_sub    = 5'd3,
        op_and    = 5'd4,
        op_or     = 5'd5,
        op_xor    = 5'd6,
        op_not_b  = 5'd7,
        op_shl_a  = 5'd8,
        op_shr_a  = 5'd9,
        op_mul    = 5'd10,
        op_swap_a = 5'd11
    } alu_op_e;

    // Host command, 44 bits
    typedef struct packed {
        instr_t instr;
        data_t  operand_a;
        data_t  operand_b;
    } cmd_t;

    // Returned result with the instruction that made it, 32 bits
    typedef struct packed {
        data_t  value;
        instr_t instr;
    } result_t;

endpackage

// File: source/cmd_fifo.sv
module cmd_fifo #(
    parameter int unsigned DEPTH = 4
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          push,
    input  alu_pkg::cmd_t push_data,
    input  logic          pop,
    output alu_pkg::cmd_t pop_data,
    output logic          full,
    output logic          empty
);

    import alu_pkg::*;

    localparam int unsigned AW = $clog2(DEPTH);

    typedef logic [AW-1:0] addr_t;
    typedef logic [AW:0]   ptr_t;

    cmd_t mem [DEPTH];

    ptr_t  wr_ptr;
    ptr_t  rd_ptr;
    addr_t wr_addr;
    addr_t rd_addr;
    logic  do_push;
    logic  do_pop;

    assign wr_addr = wr_ptr[AW-1:0];
    assign rd_addr = rd_ptr[AW-1:0];

    // Extra pointer bit tells a wrapped write pointer from an equal one
    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_addr == rd_addr);

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_addr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end else if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
        end else if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Head entry shown without waiting for a pop
    assign pop_data = mem[rd_addr];

endmodule

// File: source/cmd_receiver.sv
module cmd_receiver (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          cmd_req,
    input  alu_pkg::cmd_t cmd,
    output logic          cmd_ack,
    input  logic          full,
    output logic          push,
    output alu_pkg::cmd_t push_data
);

    typedef enum logic {
        READY,
        WAIT_RELEASE
    } rx_state_e;

    rx_state_e state;
    rx_state_e state_next;
    logic      accept;

    // Take a new request only when the FIFO has room
    assign accept = (state == READY) && cmd_req && !full;

    always_comb begin
        state_next = state;
        case (state)
            READY: begin
                if (accept) begin
                    state_next = WAIT_RELEASE;
                end
            end
            WAIT_RELEASE: begin
                // Host must drop req before the next command
                if (!cmd_req) begin
                    state_next = READY;
                end
            end
            default: begin
                state_next = READY;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= READY;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_ack <= 1'b0;
        end else if (accept) begin
            cmd_ack <= 1'b1;
        end else if (state == WAIT_RELEASE && !cmd_req) begin
            cmd_ack <= 1'b0;
        end
    end

    // Command is stored in the FIFO on the accepting edge
    assign push      = accept;
    assign push_data = cmd;

endmodule

// File: test/alu_core_assert.sv
module alu_core_assert (
    input logic             clk,
    input logic             rst_n,
    input logic             cmd_req,
    input logic             cmd_ack,
    input logic             full,
    input logic             empty,
    input logic             result_req,
    input alu_pkg::result_t result,
    input logic             result_ack
);

    timeunit 1ns;
    timeprecision 100ps;

    logic entry_seen;

    // Set once the FIFO has held anything since reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_seen <= 1'b0;
        end else if (!empty) begin
            entry_seen <= 1'b1;
        end
    end

    ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cmd_ack) |-> $past(cmd_req))
        else $error("cmd_ack rose while cmd_req was low");

    no_ack_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cmd_ack) |-> !$past(full))
        else $error("cmd_ack rose while the FIFO was full");

    result_held: assert property (@(posedge clk) disable iff (!rst_n)
        (result_req && !result_ack) |=> $stable(result))
        else $error("result changed before result_ack was seen");

    no_early_result: assert property (@(posedge clk) disable iff (!rst_n)
        !entry_seen |-> !result_req)
        else $error("result_req rose before any command reached the FIFO");

endmodule

bind alu_core_top alu_core_assert u_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_req    (cmd_req),
    .cmd_ack    (cmd_ack),
    .full       (full),
    .empty      (empty),
    .result_req (result_req),
    .result     (result),
    .result_ack (result_ack)
);

// File: test/alu_core_tb.sv
module alu_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import alu_pkg::*;

    localparam int FIFO_DEPTH  = 4;
    localparam int TOTAL_CMDS  = 8 + 26 + 28 + 12 + 200;
    localparam int WATCHDOG_NS = TOTAL_CMDS * 200 + 2000;
    localparam logic [31:0] LCG_SEED = 32'ha7f9b8bd;

    logic    clk;
    logic    rst_n;
    logic    cmd_req;
    cmd_t    cmd;
    logic    cmd_ack;
    logic    result_req;
    result_t result;
    logic    result_ack;

    data_t       shadow [32];
    result_t     expected [$];
    logic [31:0] cmd_lcg;
    logic [31:0] delay_lcg;
    int          ack_delay = 0;
    logic        random_delay = 1'b0;
    int          cmds_sent = 0;
    int          acked_count = 0;
    int          results_done = 0;
    int          max_outstanding = 0;

    tb_clock #(.PERIOD_NS(20)) u_clock (.clk(clk));

    alu_core_top #(.FIFO_DEPTH(FIFO_DEPTH)) u_alu_core_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_req    (cmd_req),
        .cmd        (cmd),
        .cmd_ack    (cmd_ack),
        .result_req (result_req),
        .result     (result),
        .result_ack (result_ack)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic instr_t make_instr(input logic [4:0] op, input logic we,
                                          input logic sel_a, input logic sel_b,
                                          input logic [4:0] fld);
        instr_t ins;
        ins        = '0;
        ins[19:15] = op;
        ins[14]    = we;
        ins[6]     = sel_a;
        ins[5]     = sel_b;
        ins[4:0]   = fld;
        return ins;
    endfunction

    function automatic cmd_t make_cmd(input instr_t ins, input data_t a, input data_t b);
        cmd_t c;
        c.instr     = ins;
        c.operand_a = a;
        c.operand_b = b;
        return c;
    endfunction

    // Opcode table worked in plain integer arithmetic
    function automatic data_t alu_model(input logic [4:0] op, input data_t a, input data_t b);
        int unsigned ia;
        int unsigned ib;
        ia = a;
        ib = b;
        case (op)
            5'd1:    return b;
            5'd2:    return data_t'((ia + ib) % 4096);
            5'd3:    return data_t'((ia + 4096 - ib) % 4096);
            5'd4:    return a & b;
            5'd5:    return a | b;
            5'd6:    return a ^ b;
            5'd7:    return data_t'(4095 - ib);
            5'd8:    return data_t'((ia * 2) % 4096);
            5'd9:    return data_t'(ia / 2);
            5'd10:   return data_t'((ia * ib) % 4096);
            5'd11:   return data_t'((ia % 64) * 64 + ia / 64);
            default: return a;
        endcase
    endfunction

    // Shadow registers follow command order, as the DUT runs one at a time
    task automatic predict(input cmd_t c);
        data_t   a;
        data_t   b;
        result_t r;
        a       = c.instr[6] ? shadow[c.instr[4:2]] : c.operand_a;
        b       = c.instr[5] ? shadow[c.instr[1:0]] : c.operand_b;
        r.value = alu_model(c.instr[19:15], a, b);
        r.instr = c.instr;
        if (c.instr[14]) begin
            shadow[c.instr[4:0]] = r.value;
        end
        expected.push_back(r);
    endtask

    task automatic send_cmd(input cmd_t c);
        int outstanding;
        predict(c);
        cmds_sent++;
        @(posedge clk);
        cmd     <= c;
        cmd_req <= 1'b1;
        do begin
            @(posedge clk);
        end while (!cmd_ack);
        outstanding = acked_count + 1 - results_done;
        assert (outstanding <= FIFO_DEPTH + 1)
            else report_failure($sformatf("%0d commands acknowledged beyond returned results",
                outstanding));
        if (outstanding > max_outstanding) begin
            max_outstanding = outstanding;
        end
        acked_count++;
        cmd_req <= 1'b0;
        do begin
            @(posedge clk);
        end while (cmd_ack);
    endtask

    task automatic wait_drain();
        while (results_done != cmds_sent) begin
            @(posedge clk);
        end
    endtask

    task automatic check_result(input result_t got);
        result_t exp;
        if (expected.size() == 0) begin
            report_failure("result returned with no command outstanding");
        end else begin
            exp = expected.pop_front();
            assert (got.value == exp.value)
                else report_failure($sformatf("mismatch at %0t: result.value got %h expected %h",
                    $time, got.value, exp.value));
            assert (got.instr == exp.instr)
                else report_failure($sformatf("mismatch at %0t: result.instr got %h expected %h",
                    $time, got.instr, exp.instr));
        end
    endtask

    task automatic verify_reset_state();
        @(posedge clk);
        assert (cmd_ack === 1'b0)
            else report_failure($sformatf("mismatch at %0t: cmd_ack got %b expected 0",
                $time, cmd_ack));
        assert (result_req === 1'b0)
            else report_failure($sformatf("mismatch at %0t: result_req got %b expected 0",
                $time, result_req));
        for (int r = 0; r < 8; r++) begin
            send_cmd(make_cmd(make_instr(5'd0, 1'b0, 1'b1, 1'b0, {r[2:0], 2'b00}),
                12'h5A5, 12'hA5A));
        end
        wait_drain();
    endtask

    task automatic sweep_opcodes();
        data_t a;
        data_t b;
        for (int p = 0; p < 2; p++) begin
            a = (p == 0) ? 12'hA5C : 12'hFC3;
            b = (p == 0) ? 12'h3F7 : 12'h07E;
            for (int op = 0; op < 12; op++) begin
                send_cmd(make_cmd(make_instr(op[4:0], 1'b0, 1'b0, 1'b0, 5'd0), a, b));
            end
            // Undefined opcode
            send_cmd(make_cmd(make_instr(5'd20, 1'b0, 1'b0, 1'b0, 5'd0), a, b));
        end
        wait_drain();
    endtask

    task automatic exercise_write_back();
        for (int r = 0; r < 8; r++) begin
            send_cmd(make_cmd(make_instr(5'd1, 1'b1, 1'b0, 1'b0, r[4:0]),
                12'h000, data_t'(161 + r * 273)));
        end
        for (int r = 0; r < 8; r++) begin
            send_cmd(make_cmd(make_instr(5'd0, 1'b0, 1'b1, 1'b0, {r[2:0], 2'b00}),
                12'hFFF, 12'hFFF));
        end
        for (int r = 0; r < 4; r++) begin
            send_cmd(make_cmd(make_instr(5'd1, 1'b0, 1'b0, 1'b1, r[4:0]), 12'hFFF, 12'hFFF));
        end
        // Same destinations without the write bit
        for (int r = 0; r < 4; r++) begin
            send_cmd(make_cmd(make_instr(5'd7, 1'b0, 1'b0, 1'b0, r[4:0]), 12'h000, 12'h0F0));
        end
        for (int r = 0; r < 4; r++) begin
            send_cmd(make_cmd(make_instr(5'd1, 1'b0, 1'b0, 1'b1, r[4:0]), 12'h000, 12'h000));
        end
        wait_drain();
    endtask

    task automatic stall_results();
        ack_delay       = 30;
        max_outstanding = 0;
        for (int i = 0; i < 12; i++) begin
            send_cmd(make_cmd(make_instr(5'd2, 1'b0, 1'b0, 1'b0, 5'd0),
                data_t'(i * 100), data_t'(7 + i)));
        end
        wait_drain();
        assert (max_outstanding == FIFO_DEPTH + 1)
            else report_failure("FIFO never filled while results were held back");
        ack_delay = 0;
    endtask

    task automatic run_random_stream();
        instr_t ins;
        data_t  a;
        data_t  b;
        random_delay = 1'b1;
        for (int i = 0; i < 200; i++) begin
            cmd_lcg = lcg_next(cmd_lcg);
            ins     = cmd_lcg[31:12];
            // Opcodes 0 to 15, mostly defined ones
            ins[19] = 1'b0;
            cmd_lcg = lcg_next(cmd_lcg);
            a       = cmd_lcg[31:20];
            b       = cmd_lcg[19:8];
            send_cmd(make_cmd(ins, a, b));
        end
        wait_drain();
        random_delay = 1'b0;
    endtask

    // Host side of the result link
    initial begin : responder
        int delay;
        delay_lcg = LCG_SEED;
        result_ack <= 1'b0;
        forever begin
            @(posedge clk);
            if (result_req) begin
                check_result(result);
                if (random_delay) begin
                    delay_lcg = lcg_next(delay_lcg);
                    delay     = int'(delay_lcg[31:30]);
                end else begin
                    delay = ack_delay;
                end
                repeat (delay) @(posedge clk);
                result_ack <= 1'b1;
                do begin
                    @(posedge clk);
                end while (result_req);
                result_ack   <= 1'b0;
                results_done <= results_done + 1;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        report_failure($sformatf("run timed out after %0d ns", WATCHDOG_NS));
    end

    initial begin : main
        rst_n   <= 1'b0;
        cmd_req <= 1'b0;
        cmd     <= '0;
        cmd_lcg = LCG_SEED;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        verify_reset_state();
        sweep_opcodes();
        exercise_write_back();
        stall_results();
        run_random_stream();
        if (expected.size() == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: test/tb_clock.sv
module tb_clock #(
    parameter int unsigned PERIOD_NS = 20
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule
